//--- hdl/glb_pkg.sv
/* Shared widths and word types for the global buffer RTL.
   Modules refer to these through glb_pkg:: scoped names. */
`default_nettype none

package glb_pkg;

    // Bank geometry
    localparam int SRAM_WIDTH = 16;
    localparam int SRAM_WORD  = 8;
    localparam int ROW_BITS   = $clog2(SRAM_WORD);

    // Pointers, counts and parallel bank width
    localparam int ADDR_WIDTH = 8;
    localparam int MAXPAR     = 2;
    localparam int PAR_WIDTH  = $clog2(MAXPAR) + 1;

    typedef logic [SRAM_WIDTH-1:0]        sram_word_t;
    // Slice i belongs to bank first plus i
    typedef logic [MAXPAR*SRAM_WIDTH-1:0] wide_word_t;
    typedef logic [ROW_BITS-1:0]          row_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [PAR_WIDTH-1:0]         par_t;

endpackage

`default_nettype wire

//--- hdl/glb_sram.sv
/* Single bank of the buffer, one write and one read port.
   Read data is registered and only changes when a read is enabled. */
`timescale 1ns/1ps
`default_nettype none

module glb_sram (
    input  wire                  clk,
    input  wire                  we_i,
    input  wire glb_pkg::row_t   waddr_i,
    input  wire glb_pkg::sram_word_t wdata_i,
    input  wire                  re_i,
    input  wire glb_pkg::row_t   raddr_i,
    output glb_pkg::sram_word_t  rdata_o
);

    glb_pkg::sram_word_t mem [glb_pkg::SRAM_WORD];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Holds the last word while the reader is stalled
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_bank_map.sv
/* Decodes the bank masks into per-bank owners and per-port first banks.
   Lowest index wins when several ports claim one bank. */
`timescale 1ns/1ps
`default_nettype none

module glb_bank_map #(
    parameter  int NUM_BANK   = 4,
    parameter  int NUM_WRPORT = 2,
    parameter  int NUM_RDPORT = 2,
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT,
    localparam int BANK_IDX_W = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1,
    localparam int WR_IDX_W   = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1,
    localparam int RD_IDX_W   = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1
) (
    input  wire  [NUM_PORT-1:0][NUM_BANK-1:0]   cfg_bank_flag_i,
    output logic [NUM_BANK-1:0][WR_IDX_W-1:0]   bank_wr_owner_o,
    output logic [NUM_BANK-1:0][RD_IDX_W-1:0]   bank_rd_owner_o,
    output logic [NUM_PORT-1:0][BANK_IDX_W-1:0] port_first_bank_o
);

    // Owner per bank, scanning downward so the lowest port is kept
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_wr_owner_o[b] = '0;
            bank_rd_owner_o[b] = '0;
            for (int p = NUM_WRPORT - 1; p >= 0; p--) begin
                if (cfg_bank_flag_i[p][b]) begin
                    bank_wr_owner_o[b] = WR_IDX_W'(p);
                end
            end
            for (int p = NUM_RDPORT - 1; p >= 0; p--) begin
                if (cfg_bank_flag_i[NUM_WRPORT+p][b]) begin
                    bank_rd_owner_o[b] = RD_IDX_W'(p);
                end
            end
        end
    end

    // Lowest set bit of each port's mask
    always_comb begin
        for (int p = 0; p < NUM_PORT; p++) begin
            port_first_bank_o[p] = '0;
            for (int b = NUM_BANK - 1; b >= 0; b--) begin
                if (cfg_bank_flag_i[p][b]) begin
                    port_first_bank_o[p] = BANK_IDX_W'(b);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/glb_wr_port.sv
/* Write side of one channel: pointer, bank group select and status.
   Free space is measured against the paired read pointer. */
`timescale 1ns/1ps
`default_nettype none

module glb_wr_port #(
    parameter  int NUM_BANK   = 4,
    localparam int BANK_IDX_W = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   cfg_vld_i,
    input  wire glb_pkg::addr_t   cfg_num_i,
    input  wire glb_pkg::par_t    cfg_par_i,
    input  wire [BANK_IDX_W-1:0]  first_bank_i,
    input  wire                   wr_dat_vld_i,
    output logic                  wr_dat_rdy_o,
    input  wire glb_pkg::addr_t   partner_ptr_i,
    output glb_pkg::addr_t        ptr_o,
    output logic [BANK_IDX_W-1:0] cur_bank_o,
    output glb_pkg::row_t         row_o,
    output logic [NUM_BANK-1:0]   bank_en_o,
    output logic                  wr_empty_o,
    output glb_pkg::addr_t        wr_req_num_o
);

    glb_pkg::addr_t occupancy;
    glb_pkg::addr_t group_base;
    logic           accept;

    assign occupancy    = ptr_o - partner_ptr_i;
    assign wr_dat_rdy_o = (occupancy != cfg_num_i);
    assign accept       = wr_dat_vld_i & wr_dat_rdy_o;

    always_ff @(posedge clk) begin
        if (reset_i || cfg_vld_i) begin
            ptr_o <= '0;
        end else if (accept) begin
            ptr_o <= ptr_o + 1'b1;
        end
    end

    // ========================================================================
    // Bank group addressing
    // ========================================================================
    // Upper pointer bits step through groups of par banks
    assign group_base = glb_pkg::addr_t'(first_bank_i)
                      + (ptr_o >> glb_pkg::ROW_BITS) * glb_pkg::addr_t'(cfg_par_i);
    assign cur_bank_o = group_base[BANK_IDX_W-1:0];
    assign row_o      = ptr_o[glb_pkg::ROW_BITS-1:0];

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_en_o[b] = accept
                && (glb_pkg::addr_t'(b) >= group_base)
                && (glb_pkg::addr_t'(b) < group_base + glb_pkg::addr_t'(cfg_par_i));
        end
    end

    // Status towards the producer
    assign wr_empty_o   = (cfg_num_i != '0) && (occupancy == '0);
    assign wr_req_num_o = cfg_num_i - occupancy;

endmodule

`default_nettype wire

//--- hdl/glb_rd_port.sv
/* Read side of one channel: issue control, pointer and wide word gather.
   Output data comes straight from the bank read registers of the last issue. */
`timescale 1ns/1ps
`default_nettype none

module glb_rd_port #(
    parameter  int NUM_BANK   = 4,
    parameter  int NUM_WRPORT = 2,
    localparam int BANK_IDX_W = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1
) (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire                   cfg_vld_i,
    input  wire glb_pkg::addr_t   cfg_num_i,
    input  wire glb_pkg::par_t    cfg_par_i,
    input  wire [BANK_IDX_W-1:0]  first_bank_i,
    input  wire glb_pkg::addr_t   partner_ptr_i,
    output glb_pkg::addr_t        ptr_o,
    output logic [BANK_IDX_W-1:0] cur_bank_o,
    output glb_pkg::row_t         row_o,
    output logic [NUM_BANK-1:0]   bank_en_o,
    input  wire glb_pkg::sram_word_t [NUM_BANK-1:0] bank_rdata_i,
    output glb_pkg::wide_word_t   rd_dat_o,
    output logic                  rd_dat_vld_o,
    input  wire                   rd_dat_rdy_i,
    output logic                  rd_full_o,
    output glb_pkg::addr_t        rd_req_num_o
);

    glb_pkg::addr_t        occupancy;
    glb_pkg::addr_t        group_base;
    logic                  issue;
    logic [BANK_IDX_W-1:0] issued_bank;

    // A channel needs a producer and enough banks for the widest word
    if (NUM_WRPORT < 1 || NUM_BANK < glb_pkg::MAXPAR) begin : g_param_check
        $error("glb_rd_port: need a write port and at least MAXPAR banks");
    end

    assign occupancy = partner_ptr_i - ptr_o;
    // Issue only when the output slot is free or being taken this cycle
    assign issue     = (occupancy != '0) && (!rd_dat_vld_o || rd_dat_rdy_i);

    always_ff @(posedge clk) begin
        if (reset_i || cfg_vld_i) begin
            ptr_o <= '0;
        end else if (issue) begin
            ptr_o <= ptr_o + 1'b1;
        end
    end

    // ========================================================================
    // Bank group addressing
    // ========================================================================
    assign group_base = glb_pkg::addr_t'(first_bank_i)
                      + (ptr_o >> glb_pkg::ROW_BITS) * glb_pkg::addr_t'(cfg_par_i);
    assign cur_bank_o = group_base[BANK_IDX_W-1:0];
    assign row_o      = ptr_o[glb_pkg::ROW_BITS-1:0];

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            bank_en_o[b] = issue
                && (glb_pkg::addr_t'(b) >= group_base)
                && (glb_pkg::addr_t'(b) < group_base + glb_pkg::addr_t'(cfg_par_i));
        end
    end

    // ========================================================================
    // Output word
    // ========================================================================
    always_ff @(posedge clk) begin
        if (issue) begin
            issued_bank <= cur_bank_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || cfg_vld_i) begin
            rd_dat_vld_o <= 1'b0;
        end else if (issue) begin
            rd_dat_vld_o <= 1'b1;
        end else if (rd_dat_rdy_i) begin
            rd_dat_vld_o <= 1'b0;
        end
    end

    // Slices above par read as zero
    always_comb begin
        rd_dat_o = '0;
        for (int i = 0; i < glb_pkg::MAXPAR; i++) begin
            if (i < int'(cfg_par_i) && int'(issued_bank) + i < NUM_BANK) begin
                rd_dat_o[i*glb_pkg::SRAM_WIDTH +: glb_pkg::SRAM_WIDTH] =
                    bank_rdata_i[int'(issued_bank) + i];
            end
        end
    end

    assign rd_full_o    = (cfg_num_i != '0) && (occupancy == cfg_num_i);
    assign rd_req_num_o = occupancy;

endmodule

`default_nettype wire

//--- hdl/glb_bank_array.sv
/* Row of banks, each driven by the write and read port that owns it.
   Write data slices are picked by the bank's offset in the port's group. */
`timescale 1ns/1ps
`default_nettype none

module glb_bank_array #(
    parameter  int NUM_BANK   = 4,
    parameter  int NUM_WRPORT = 2,
    parameter  int NUM_RDPORT = 2,
    localparam int BANK_IDX_W = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1,
    localparam int WR_IDX_W   = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1,
    localparam int RD_IDX_W   = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1
) (
    input  wire                                   clk,
    input  wire  [NUM_BANK-1:0][WR_IDX_W-1:0]     bank_wr_owner_i,
    input  wire  [NUM_BANK-1:0][RD_IDX_W-1:0]     bank_rd_owner_i,
    input  wire  [NUM_WRPORT-1:0][NUM_BANK-1:0]   wr_bank_en_i,
    input  wire glb_pkg::row_t [NUM_WRPORT-1:0]   wr_row_i,
    input  wire  [NUM_WRPORT-1:0][BANK_IDX_W-1:0] wr_first_bank_i,
    input  wire glb_pkg::wide_word_t [NUM_WRPORT-1:0] wr_dat_i,
    input  wire  [NUM_RDPORT-1:0][NUM_BANK-1:0]   rd_bank_en_i,
    input  wire glb_pkg::row_t [NUM_RDPORT-1:0]   rd_row_i,
    output glb_pkg::sram_word_t [NUM_BANK-1:0]    bank_rdata_o
);

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic [WR_IDX_W-1:0]   wr_port;
        logic [RD_IDX_W-1:0]   rd_port;
        logic [BANK_IDX_W-1:0] offset;
        glb_pkg::sram_word_t   wdata;

        assign wr_port = bank_wr_owner_i[b];
        assign rd_port = bank_rd_owner_i[b];

        // Position of this bank inside the writer's current group
        assign offset = BANK_IDX_W'(b) - wr_first_bank_i[wr_port];

        always_comb begin
            wdata = '0;
            for (int i = 0; i < glb_pkg::MAXPAR; i++) begin
                if (int'(offset) == i) begin
                    wdata = wr_dat_i[wr_port][i*glb_pkg::SRAM_WIDTH +: glb_pkg::SRAM_WIDTH];
                end
            end
        end

        glb_sram i_sram (
            .clk     (clk),
            .we_i    (wr_bank_en_i[wr_port][b]),
            .waddr_i (wr_row_i[wr_port]),
            .wdata_i (wdata),
            .re_i    (rd_bank_en_i[rd_port][b]),
            .raddr_i (rd_row_i[rd_port]),
            .rdata_o (bank_rdata_o[b])
        );
    end

endmodule

`default_nettype wire

//--- hdl/glb_top.sv
/* Global buffer top: bank map, write and read ports and the bank array.
   Each port finds its partner through the owner of its current bank. */
`timescale 1ns/1ps
`default_nettype none

module glb_top #(
    parameter  int NUM_BANK   = 4,
    parameter  int NUM_WRPORT = 2,
    parameter  int NUM_RDPORT = 2,
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT,
    localparam int BANK_IDX_W = (NUM_BANK > 1) ? $clog2(NUM_BANK) : 1,
    localparam int WR_IDX_W   = (NUM_WRPORT > 1) ? $clog2(NUM_WRPORT) : 1,
    localparam int RD_IDX_W   = (NUM_RDPORT > 1) ? $clog2(NUM_RDPORT) : 1
) (
    input  wire                                    clk,
    input  wire                                    reset_i,
    // Configuration, write ports first
    input  wire  [NUM_PORT-1:0]                    cfg_vld_i,
    input  wire  [NUM_PORT-1:0][NUM_BANK-1:0]      cfg_bank_flag_i,
    input  wire glb_pkg::addr_t [NUM_PORT-1:0]     cfg_num_i,
    input  wire glb_pkg::par_t [NUM_PORT-1:0]      cfg_par_i,
    // Write side
    input  wire glb_pkg::wide_word_t [NUM_WRPORT-1:0] wr_dat_i,
    input  wire  [NUM_WRPORT-1:0]                  wr_dat_vld_i,
    output logic [NUM_WRPORT-1:0]                  wr_dat_rdy_o,
    output logic [NUM_WRPORT-1:0]                  wr_empty_o,
    output glb_pkg::addr_t [NUM_WRPORT-1:0]        wr_req_num_o,
    // Read side
    output glb_pkg::wide_word_t [NUM_RDPORT-1:0]   rd_dat_o,
    output logic [NUM_RDPORT-1:0]                  rd_dat_vld_o,
    input  wire  [NUM_RDPORT-1:0]                  rd_dat_rdy_i,
    output logic [NUM_RDPORT-1:0]                  rd_full_o,
    output glb_pkg::addr_t [NUM_RDPORT-1:0]        rd_req_num_o
);

    logic [NUM_BANK-1:0][WR_IDX_W-1:0]     bank_wr_owner;
    logic [NUM_BANK-1:0][RD_IDX_W-1:0]     bank_rd_owner;
    logic [NUM_PORT-1:0][BANK_IDX_W-1:0]   port_first_bank;

    glb_pkg::addr_t [NUM_WRPORT-1:0]       wr_ptr;
    logic [NUM_WRPORT-1:0][BANK_IDX_W-1:0] wr_cur_bank;
    glb_pkg::row_t [NUM_WRPORT-1:0]        wr_row;
    logic [NUM_WRPORT-1:0][NUM_BANK-1:0]   wr_bank_en;

    glb_pkg::addr_t [NUM_RDPORT-1:0]       rd_ptr;
    logic [NUM_RDPORT-1:0][BANK_IDX_W-1:0] rd_cur_bank;
    glb_pkg::row_t [NUM_RDPORT-1:0]        rd_row;
    logic [NUM_RDPORT-1:0][NUM_BANK-1:0]   rd_bank_en;

    glb_pkg::sram_word_t [NUM_BANK-1:0]    bank_rdata;

    glb_bank_map #(
        .NUM_BANK   (NUM_BANK),
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) i_bank_map (
        .cfg_bank_flag_i   (cfg_bank_flag_i),
        .bank_wr_owner_o   (bank_wr_owner),
        .bank_rd_owner_o   (bank_rd_owner),
        .port_first_bank_o (port_first_bank)
    );

    // ========================================================================
    // Write ports
    // ========================================================================
    for (genvar w = 0; w < NUM_WRPORT; w++) begin : g_wr_port
        glb_pkg::addr_t partner_ptr;

        // Reader owning the bank this port is about to fill
        assign partner_ptr = rd_ptr[bank_rd_owner[wr_cur_bank[w]]];

        glb_wr_port #(
            .NUM_BANK (NUM_BANK)
        ) i_wr_port (
            .clk           (clk),
            .reset_i       (reset_i),
            .cfg_vld_i     (cfg_vld_i[w]),
            .cfg_num_i     (cfg_num_i[w]),
            .cfg_par_i     (cfg_par_i[w]),
            .first_bank_i  (port_first_bank[w]),
            .wr_dat_vld_i  (wr_dat_vld_i[w]),
            .wr_dat_rdy_o  (wr_dat_rdy_o[w]),
            .partner_ptr_i (partner_ptr),
            .ptr_o         (wr_ptr[w]),
            .cur_bank_o    (wr_cur_bank[w]),
            .row_o         (wr_row[w]),
            .bank_en_o     (wr_bank_en[w]),
            .wr_empty_o    (wr_empty_o[w]),
            .wr_req_num_o  (wr_req_num_o[w])
        );
    end

    // ========================================================================
    // Read ports
    // ========================================================================
    for (genvar r = 0; r < NUM_RDPORT; r++) begin : g_rd_port
        glb_pkg::addr_t partner_ptr;

        assign partner_ptr = wr_ptr[bank_wr_owner[rd_cur_bank[r]]];

        glb_rd_port #(
            .NUM_BANK   (NUM_BANK),
            .NUM_WRPORT (NUM_WRPORT)
        ) i_rd_port (
            .clk           (clk),
            .reset_i       (reset_i),
            .cfg_vld_i     (cfg_vld_i[NUM_WRPORT+r]),
            .cfg_num_i     (cfg_num_i[NUM_WRPORT+r]),
            .cfg_par_i     (cfg_par_i[NUM_WRPORT+r]),
            .first_bank_i  (port_first_bank[NUM_WRPORT+r]),
            .partner_ptr_i (partner_ptr),
            .ptr_o         (rd_ptr[r]),
            .cur_bank_o    (rd_cur_bank[r]),
            .row_o         (rd_row[r]),
            .bank_en_o     (rd_bank_en[r]),
            .bank_rdata_i  (bank_rdata),
            .rd_dat_o      (rd_dat_o[r]),
            .rd_dat_vld_o  (rd_dat_vld_o[r]),
            .rd_dat_rdy_i  (rd_dat_rdy_i[r]),
            .rd_full_o     (rd_full_o[r]),
            .rd_req_num_o  (rd_req_num_o[r])
        );
    end

    glb_bank_array #(
        .NUM_BANK   (NUM_BANK),
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) i_bank_array (
        .clk             (clk),
        .bank_wr_owner_i (bank_wr_owner),
        .bank_rd_owner_i (bank_rd_owner),
        .wr_bank_en_i    (wr_bank_en),
        .wr_row_i        (wr_row),
        .wr_first_bank_i (wr_cur_bank),
        .wr_dat_i        (wr_dat_i),
        .rd_bank_en_i    (rd_bank_en),
        .rd_row_i        (rd_row),
        .bank_rdata_o    (bank_rdata)
    );

endmodule

`default_nettype wire

//--- verif/glb_properties.sv
/* Port assertions bound into the buffer top level.
   Covers read output hold, ready against full, and the reset state. */
`timescale 1ns/1ps
`default_nettype none

module glb_properties #(
    parameter  int NUM_WRPORT = 2,
    parameter  int NUM_RDPORT = 2,
    localparam int NUM_PAIR   = (NUM_WRPORT < NUM_RDPORT) ? NUM_WRPORT : NUM_RDPORT
) (
    input  wire                                       clk,
    input  wire                                       reset_i,
    input  wire glb_pkg::wide_word_t [NUM_RDPORT-1:0] rd_dat_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_dat_vld_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_dat_rdy_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_full_i,
    input  wire  [NUM_WRPORT-1:0]                     wr_dat_rdy_i
);

    int fail_count = 0;

    // Stalled output keeps its word and valid
    for (genvar r = 0; r < NUM_RDPORT; r++) begin : g_rd
        hold_a: assert property (@(posedge clk) disable iff (reset_i)
            rd_dat_vld_i[r] && !rd_dat_rdy_i[r] |=> rd_dat_vld_i[r] && $stable(rd_dat_i[r]))
        else begin
            fail_count++;
            $error("read port %0d changed its output under back-pressure", r);
        end
    end

    for (genvar p = 0; p < NUM_PAIR; p++) begin : g_pair
        full_a: assert property (@(posedge clk) disable iff (reset_i)
            !(wr_dat_rdy_i[p] && rd_full_i[p]))
        else begin
            fail_count++;
            $error("pair %0d shows write ready while full", p);
        end
    end

    reset_a: assert property (@(posedge clk) reset_i |=> rd_dat_vld_i == '0)
    else begin
        fail_count++;
        $error("read valid high right after reset");
    end

endmodule

bind glb_top glb_properties #(
    .NUM_WRPORT (NUM_WRPORT),
    .NUM_RDPORT (NUM_RDPORT)
) i_glb_properties (
    .clk          (clk),
    .reset_i      (reset_i),
    .rd_dat_i     (rd_dat_o),
    .rd_dat_vld_i (rd_dat_vld_o),
    .rd_dat_rdy_i (rd_dat_rdy_i),
    .rd_full_i    (rd_full_o),
    .wr_dat_rdy_i (wr_dat_rdy_o)
);

`default_nettype wire

//--- verif/glb_checker.sv
/* Scoreboard for the buffer with one word queue per write and read pair.
   Status is compared every cycle, read data on every read handshake. */
`timescale 1ns/1ps
`default_nettype none

module glb_checker #(
    parameter  int NUM_WRPORT = 2,
    parameter  int NUM_RDPORT = 2,
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT,
    localparam int NUM_PAIR   = (NUM_WRPORT < NUM_RDPORT) ? NUM_WRPORT : NUM_RDPORT
) (
    input  wire                                       clk,
    input  wire                                       reset_i,
    input  wire  [NUM_PORT-1:0]                       cfg_vld_i,
    input  wire glb_pkg::addr_t [NUM_PORT-1:0]        cfg_num_i,
    input  wire glb_pkg::par_t [NUM_PORT-1:0]         cfg_par_i,
    input  wire glb_pkg::wide_word_t [NUM_WRPORT-1:0] wr_dat_i,
    input  wire  [NUM_WRPORT-1:0]                     wr_dat_vld_i,
    input  wire  [NUM_WRPORT-1:0]                     wr_dat_rdy_i,
    input  wire  [NUM_WRPORT-1:0]                     wr_empty_i,
    input  wire glb_pkg::addr_t [NUM_WRPORT-1:0]      wr_req_num_i,
    input  wire glb_pkg::wide_word_t [NUM_RDPORT-1:0] rd_dat_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_dat_vld_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_dat_rdy_i,
    input  wire  [NUM_RDPORT-1:0]                     rd_full_i,
    input  wire glb_pkg::addr_t [NUM_RDPORT-1:0]      rd_req_num_i,
    output int                                        error_count_o
);

    // Words accepted and not yet delivered, per pair
    glb_pkg::wide_word_t chan_q [NUM_PAIR][$];

    initial error_count_o = 0;

    // Banks only hold the first par slices of a word
    function automatic glb_pkg::wide_word_t keep_slices(glb_pkg::wide_word_t word, int par);
        glb_pkg::wide_word_t result;
        result = '0;
        for (int i = 0; i < par && i < glb_pkg::MAXPAR; i++) begin
            result[i*glb_pkg::SRAM_WIDTH +: glb_pkg::SRAM_WIDTH] =
                word[i*glb_pkg::SRAM_WIDTH +: glb_pkg::SRAM_WIDTH];
        end
        return result;
    endfunction

    task automatic compare(input string name, input int port,
                           input glb_pkg::wide_word_t expected,
                           input glb_pkg::wide_word_t actual);
        if (expected !== actual) begin
            error_count_o++;
            $display("CHECK FAILED %s[%0d] expected %h actual %h at %0t",
                     name, port, expected, actual, $time);
        end
    endtask

    // Occupancy counts issued reads and leaves out the word held at the output
    task automatic check_status(input int p);
        glb_pkg::addr_t occ;
        glb_pkg::addr_t wr_num;
        glb_pkg::addr_t rd_num;
        occ    = glb_pkg::addr_t'(chan_q[p].size()) - glb_pkg::addr_t'(rd_dat_vld_i[p]);
        wr_num = cfg_num_i[p];
        rd_num = cfg_num_i[NUM_WRPORT+p];
        compare("rd_req_num_o", p, occ, rd_req_num_i[p]);
        compare("wr_req_num_o", p, wr_num - occ, wr_req_num_i[p]);
        compare("wr_dat_rdy_o", p, occ != wr_num, wr_dat_rdy_i[p]);
        compare("wr_empty_o", p, wr_num != '0 && occ == '0, wr_empty_i[p]);
        compare("rd_full_o", p, rd_num != '0 && occ == rd_num, rd_full_i[p]);
    endtask

    task automatic update_model(input int p);
        glb_pkg::wide_word_t expected;
        if (cfg_vld_i[p] || cfg_vld_i[NUM_WRPORT+p]) begin
            chan_q[p].delete();
        end else begin
            if (rd_dat_vld_i[p] && rd_dat_rdy_i[p]) begin
                if (chan_q[p].size() == 0) begin
                    error_count_o++;
                    $display("Read port %0d delivered a word that was never written", p);
                end else begin
                    expected = chan_q[p].pop_front();
                    compare("rd_dat_o", p, expected, rd_dat_i[p]);
                end
            end
            if (wr_dat_vld_i[p] && wr_dat_rdy_i[p]) begin
                chan_q[p].push_back(keep_slices(wr_dat_i[p], int'(cfg_par_i[p])));
            end
        end
    endtask

    // Falling edge sees the values the next rising edge will take
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PAIR; p++) begin
            if (reset_i) begin
                chan_q[p].delete();
            end else begin
                check_status(p);
                update_model(p);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/glb_tb.sv
/* Testbench for the global buffer, driven line by line from the stimulus file.
   Run from the project root so the stimulus path resolves. */
`timescale 1ns/1ps
`default_nettype none

module glb_tb;

    localparam int    NUM_BANK       = 4;
    localparam int    NUM_WRPORT     = 2;
    localparam int    NUM_RDPORT     = 2;
    localparam int    NUM_PORT       = NUM_WRPORT + NUM_RDPORT;
    localparam int    TIMEOUT_CYCLES = 100;
    localparam string STIM_FILE      = "verif/glb_stim.txt";

    logic clk = 1'b0;
    logic reset_i;

    logic [NUM_PORT-1:0]                      cfg_vld;
    logic [NUM_PORT-1:0][NUM_BANK-1:0]        cfg_bank_flag;
    glb_pkg::addr_t [NUM_PORT-1:0]            cfg_num;
    glb_pkg::par_t [NUM_PORT-1:0]             cfg_par;
    glb_pkg::wide_word_t [NUM_WRPORT-1:0]     wr_dat;
    logic [NUM_WRPORT-1:0]                    wr_dat_vld;
    logic [NUM_WRPORT-1:0]                    wr_dat_rdy;
    logic [NUM_WRPORT-1:0]                    wr_empty;
    glb_pkg::addr_t [NUM_WRPORT-1:0]          wr_req_num;
    glb_pkg::wide_word_t [NUM_RDPORT-1:0]     rd_dat;
    logic [NUM_RDPORT-1:0]                    rd_dat_vld;
    logic [NUM_RDPORT-1:0]                    rd_dat_rdy;
    logic [NUM_RDPORT-1:0]                    rd_full;
    glb_pkg::addr_t [NUM_RDPORT-1:0]          rd_req_num;

    int check_errors;
    int assert_errors = 0;
    int run_errors    = 0;

    always #5 clk = ~clk;

    glb_top #(
        .NUM_BANK   (NUM_BANK),
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) i_glb_top (
        .clk             (clk),
        .reset_i         (reset_i),
        .cfg_vld_i       (cfg_vld),
        .cfg_bank_flag_i (cfg_bank_flag),
        .cfg_num_i       (cfg_num),
        .cfg_par_i       (cfg_par),
        .wr_dat_i        (wr_dat),
        .wr_dat_vld_i    (wr_dat_vld),
        .wr_dat_rdy_o    (wr_dat_rdy),
        .wr_empty_o      (wr_empty),
        .wr_req_num_o    (wr_req_num),
        .rd_dat_o        (rd_dat),
        .rd_dat_vld_o    (rd_dat_vld),
        .rd_dat_rdy_i    (rd_dat_rdy),
        .rd_full_o       (rd_full),
        .rd_req_num_o    (rd_req_num)
    );

    glb_checker #(
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) i_glb_checker (
        .clk           (clk),
        .reset_i       (reset_i),
        .cfg_vld_i     (cfg_vld),
        .cfg_num_i     (cfg_num),
        .cfg_par_i     (cfg_par),
        .wr_dat_i      (wr_dat),
        .wr_dat_vld_i  (wr_dat_vld),
        .wr_dat_rdy_i  (wr_dat_rdy),
        .wr_empty_i    (wr_empty),
        .wr_req_num_i  (wr_req_num),
        .rd_dat_i      (rd_dat),
        .rd_dat_vld_i  (rd_dat_vld),
        .rd_dat_rdy_i  (rd_dat_rdy),
        .rd_full_i     (rd_full),
        .rd_req_num_i  (rd_req_num),
        .error_count_o (check_errors)
    );

    // ========================================================================
    // Drive helpers that change inputs 1 ns after the rising edge
    // ========================================================================
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic pulse_config(input logic [31:0] mask);
        cfg_vld = mask[NUM_PORT-1:0];
        step();
        cfg_vld = '0;
    endtask

    // Valid stays up until the port takes the word
    task automatic write_word(input int port, input logic [31:0] data);
        int  n;
        logic accepted;
        n        = 0;
        accepted = 1'b0;
        wr_dat[port]     = data;
        wr_dat_vld[port] = 1'b1;
        while (!accepted && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            accepted = wr_dat_rdy[port];
            step();
            n++;
        end
        wr_dat_vld[port] = 1'b0;
        if (!accepted) begin
            run_errors++;
            $display("Timeout: write port %0d took no word in %0d cycles", port, n);
        end
    endtask

    task automatic drain_port(input int port);
        int  n;
        logic empty;
        n     = 0;
        empty = 1'b0;
        while (!empty && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            empty = (rd_req_num[port] == '0) && !rd_dat_vld[port];
            step();
            n++;
        end
        if (!empty) begin
            run_errors++;
            $display("Timeout: read port %0d did not drain in %0d cycles", port, n);
        end
    endtask

    task automatic run_stimulus();
        int          fd;
        string       line;
        logic [7:0]  kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            run_errors++;
            $display("Could not open stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && run_errors == 0) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    void'($sscanf(line, "%c %h %h %h %h", kind, f0, f1, f2, f3));
                    case (kind)
                        "C": begin
                            cfg_bank_flag[f0] = f1[NUM_BANK-1:0];
                            cfg_num[f0]       = glb_pkg::addr_t'(f2);
                            cfg_par[f0]       = glb_pkg::par_t'(f3);
                        end
                        "P": pulse_config(f0);
                        "W": write_word(int'(f0), f1);
                        "V": begin
                            wr_dat[f0]     = f1;
                            wr_dat_vld[f0] = 1'b1;
                        end
                        "R": begin
                            rd_dat_rdy[f0] = f1[0];
                            wait_cycles(int'(f2));
                        end
                        "I": wait_cycles(int'(f0));
                        "D": drain_port(int'(f0));
                        default: begin
                            run_errors++;
                            $display("Unknown stimulus line: %s", line);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        cfg_vld       = '0;
        cfg_bank_flag = '0;
        cfg_num       = '0;
        cfg_par       = '0;
        wr_dat        = '0;
        wr_dat_vld    = '0;
        rd_dat_rdy    = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;
        run_stimulus();
        wait_cycles(4);
        assert_errors = i_glb_top.i_glb_properties.fail_count;
        $display("Errors: %0d check, %0d assertion, %0d run",
                 check_errors, assert_errors, run_errors);
        if (check_errors == 0 && assert_errors == 0 && run_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- glb_top.f
hdl/glb_pkg.sv
hdl/glb_sram.sv
hdl/glb_bank_map.sv
hdl/glb_wr_port.sv
hdl/glb_rd_port.sv
hdl/glb_bank_array.sv
hdl/glb_top.sv
verif/glb_properties.sv
verif/glb_checker.sv
verif/glb_tb.sv

//--- Bender.yml
package:
  name: glb

sources:
  - hdl/glb_pkg.sv
  - hdl/glb_sram.sv
  - hdl/glb_bank_map.sv
  - hdl/glb_wr_port.sv
  - hdl/glb_rd_port.sv
  - hdl/glb_bank_array.sv
  - hdl/glb_top.sv
  - target: test
    files:
      - verif/glb_properties.sv
      - verif/glb_checker.sv
      - verif/glb_tb.sv

//--- verif/glb_stim.txt
# C cfg_index mask num par | P cfg_vld_mask | W port data | V port data (held, no wait)
# R rd_port level cycles | I cycles | D rd_port (wait for drain); all numbers hex
C 0 3 8 2
C 1 c c 1
C 2 3 8 2
C 3 c c 1
P f
I 4
R 0 1 0
R 1 1 0
W 0 11110001
W 1 ffff2001
W 0 22220002
W 1 eeee2002
W 0 33330003
W 1 dddd2003
D 0
D 1
R 0 0 1
W 0 a5a50004
W 1 cccc2004
W 0 5a5a0005
W 0 a5a50006
W 0 5a5a0007
I 6
R 0 1 0
D 0
D 1
P f
I 2
R 1 0 1
W 1 ab003001
W 1 ab003002
W 1 ab003003
W 1 ab003004
W 1 ab003005
W 1 ab003006
W 1 ab003007
W 1 ab003008
W 1 ab003009
W 1 ab00300a
W 1 ab00300b
W 1 ab00300c
W 1 ab00300d
W 0 77770001
D 0
V 1 ab00300e
I 5
R 1 1 0
W 1 ab00300e
D 1
I 4
